// ==== rtl/rs_pkg.sv ====
// Shared widths, functional-unit codes and execution latencies
// for the issue stage, plus the writeback slot mask function
package rs_pkg;

	// ********************
	// Sizes and widths
	// ********************
	localparam int RS_ENT_NUM = 8;
	localparam int RS_IDX_W = 3;
	localparam int PRF_IDX_W = 6;
	localparam int ROB_IDX_W = 5;
	// One bit per unresolved branch
	localparam int BR_TAG_W = 4;
	localparam int IR_W = 32;
	localparam int FU_SEL_W = 3;

	// ********************
	// Functional units
	// ********************
	localparam logic [FU_SEL_W-1:0] FU_SEL_ALU = 3'd0;
	localparam logic [FU_SEL_W-1:0] FU_SEL_COND_BRANCH = 3'd1;
	localparam logic [FU_SEL_W-1:0] FU_SEL_UNCOND_BRANCH = 3'd2;
	localparam logic [FU_SEL_W-1:0] FU_SEL_LOAD = 3'd3;
	localparam logic [FU_SEL_W-1:0] FU_SEL_STORE = 3'd4;
	localparam logic [FU_SEL_W-1:0] FU_SEL_MULT = 3'd5;

	// Execution latency in cycles
	localparam int EX_CYCLES_ALU = 1;
	localparam int EX_CYCLES_BRANCH = 1;
	localparam int EX_CYCLES_LOAD = 3;
	localparam int EX_CYCLES_STORE = 1;
	localparam int EX_CYCLES_MULT = 4;
	localparam int EX_CYCLES_MAX = 4;

	// One-hot writeback slot, bit (MAX - latency)
	// Unknown codes give all ones so they only go when the pipe is empty
	function automatic logic [EX_CYCLES_MAX-1:0] wb_slot_mask(
		input logic [FU_SEL_W-1:0] fu_sel
	);
		logic [EX_CYCLES_MAX-1:0] mask;
		int lat;
		mask = '0;
		lat = 0;
		case (fu_sel)
			FU_SEL_ALU: lat = EX_CYCLES_ALU;
			FU_SEL_COND_BRANCH, FU_SEL_UNCOND_BRANCH: lat = EX_CYCLES_BRANCH;
			FU_SEL_LOAD: lat = EX_CYCLES_LOAD;
			FU_SEL_STORE: lat = EX_CYCLES_STORE;
			FU_SEL_MULT: lat = EX_CYCLES_MULT;
			default: lat = 0;
		endcase
		if (lat == 0)
			mask = '1;
		else
			mask[EX_CYCLES_MAX - lat] = 1'b1;
		return mask;
	endfunction

endpackage

// ==== rtl/rs_entry.sv ====
`timescale 1ns/1ns
// Single reservation station entry: tags, payload, operand ready bits
// and branch mask, with CDB wakeup and branch squash
module rs_entry
	import rs_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,

	// Dispatch fields
	input  logic [PRF_IDX_W-1:0] dest_tag_i,
	input  logic [PRF_IDX_W-1:0] opa_tag_i,
	input  logic [PRF_IDX_W-1:0] opb_tag_i,
	input  logic                 opa_rdy_i,
	input  logic                 opb_rdy_i,
	input  logic [FU_SEL_W-1:0]  fu_sel_i,
	input  logic [IR_W-1:0]      ir_i,
	input  logic [ROB_IDX_W-1:0] rob_idx_i,
	input  logic [BR_TAG_W-1:0]  br_mask_i,

	// Broadcast and control
	input  logic [PRF_IDX_W-1:0] cdb_tag_i,
	input  logic                 cdb_vld_i,
	input  logic                 load_i,
	input  logic                 iss_en_i,
	input  logic                 br_recovery_i,
	input  logic [BR_TAG_W-1:0]  br_fix_i,

	output logic                 avail_o,
	output logic                 rdy_o,
	output logic [PRF_IDX_W-1:0] opa_tag_o,
	output logic [PRF_IDX_W-1:0] opb_tag_o,
	output logic [PRF_IDX_W-1:0] dest_tag_o,
	output logic [FU_SEL_W-1:0]  fu_sel_o,
	output logic [IR_W-1:0]      ir_o,
	output logic [ROB_IDX_W-1:0] rob_idx_o
);

	logic                 vld_r;
	logic                 opa_rdy_r;
	logic                 opb_rdy_r;
	logic [BR_TAG_W-1:0]  br_mask_r;
	logic                 opa_wake_in;
	logic                 opb_wake_in;
	logic                 opa_wake;
	logic                 opb_wake;
	logic                 squash;

	// CDB hit on the incoming tags, same cycle as dispatch
	assign opa_wake_in = cdb_vld_i & (cdb_tag_i == opa_tag_i);
	assign opb_wake_in = cdb_vld_i & (cdb_tag_i == opb_tag_i);

	// CDB hit on the stored tags while waiting
	assign opa_wake = cdb_vld_i & (cdb_tag_i == opa_tag_o);
	assign opb_wake = cdb_vld_i & (cdb_tag_i == opb_tag_o);

	// Entry depends on a mispredicted branch
	assign squash = br_recovery_i & (|(br_mask_r & br_fix_i));

	// ********************
	// Control state
	// ********************
	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r <= 1'b0;
			opa_rdy_r <= 1'b0;
			opb_rdy_r <= 1'b0;
		end else if (load_i) begin
			vld_r <= 1'b1;
			opa_rdy_r <= opa_rdy_i | opa_wake_in;
			opb_rdy_r <= opb_rdy_i | opb_wake_in;
		end else if (iss_en_i | squash) begin
			vld_r <= 1'b0;
			opa_rdy_r <= 1'b0;
			opb_rdy_r <= 1'b0;
		end else if (vld_r) begin
			if (opa_wake)
				opa_rdy_r <= 1'b1;
			if (opb_wake)
				opb_rdy_r <= 1'b1;
		end
	end

	// Payload, captured on load only
	always_ff @(posedge clk) begin
		if (load_i) begin
			dest_tag_o <= dest_tag_i;
			opa_tag_o <= opa_tag_i;
			opb_tag_o <= opb_tag_i;
			fu_sel_o <= fu_sel_i;
			ir_o <= ir_i;
			rob_idx_o <= rob_idx_i;
			br_mask_r <= br_mask_i;
		end
	end

	assign avail_o = ~vld_r;
	assign rdy_o = vld_r & opa_rdy_r & opb_rdy_r;

endmodule

// ==== rtl/prio_select.sv ====
`timescale 1ns/1ns
// Lowest-index priority selector with one-hot grant and binary index
module prio_select
	import rs_pkg::*;
#(
	parameter int NUM_BITS = RS_ENT_NUM,
	localparam int IDX_W = (NUM_BITS > 1) ? $clog2(NUM_BITS) : 1
) (
	input  logic [NUM_BITS-1:0] req_i,
	input  logic                en_i,

	output logic [NUM_BITS-1:0] gnt_o,
	output logic [IDX_W-1:0]    idx_o,
	output logic                any_o
);

	// Walk from the top down so the lowest set request wins.
	// Grant and index come from the same loop and always agree
	always_comb begin
		gnt_o = '0;
		idx_o = '0;
		if (en_i) begin
			for (int i = NUM_BITS - 1; i >= 0; i--) begin
				if (req_i[i]) begin
					gnt_o = '0;
					gnt_o[i] = 1'b1;
					idx_o = IDX_W'(i);
				end
			end
		end
	end

	// High whenever a grant is made
	assign any_o = en_i & (|req_i);

endmodule

// ==== rtl/wb_scheduler.sv ====
`timescale 1ns/1ns
// Completion-slot register and per-entry writeback conflict check
module wb_scheduler
	import rs_pkg::*;
(
	input  logic                               clk,
	input  logic                               rst,

	// Unit code of every entry
	input  logic [RS_ENT_NUM-1:0][FU_SEL_W-1:0] fu_sel_vec_i,
	input  logic                               iss_vld_i,
	input  logic [RS_IDX_W-1:0]                iss_idx_i,

	output logic [RS_ENT_NUM-1:0]              allow_vec_o
);

	// Bit k set: a writeback is pending, shifting toward the top each cycle
	logic [EX_CYCLES_MAX-1:0]                  sched_r;
	logic [EX_CYCLES_MAX-1:0]                  sched_nxt;
	logic [RS_ENT_NUM-1:0][EX_CYCLES_MAX-1:0]  slot_vec;

	// ********************
	// Conflict check
	// ********************
	// Entry mask bit k lines up with register bit k-1, which is where
	// the register will sit after the next shift
	always_comb begin
		for (int i = 0; i < RS_ENT_NUM; i++) begin
			slot_vec[i] = wb_slot_mask(fu_sel_vec_i[i]);
			allow_vec_o[i] = ~(|((slot_vec[i] >> 1) & sched_r));
		end
	end

	// ********************
	// Slot register
	// ********************
	always_comb begin
		sched_nxt = {sched_r[EX_CYCLES_MAX-2:0], 1'b0};
		if (iss_vld_i)
			sched_nxt = sched_nxt | slot_vec[iss_idx_i];
	end

	always_ff @(posedge clk) begin
		if (rst)
			sched_r <= '0;
		else
			sched_r <= sched_nxt;
	end

endmodule

// ==== rtl/rs.sv ====
`timescale 1ns/1ns
// Reservation station top: eight entries, dispatch and issue selectors,
// writeback scheduler, issue mux and full flag
module rs
	import rs_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,

	// From rename
	input  logic [PRF_IDX_W-1:0] dest_tag_i,
	input  logic [PRF_IDX_W-1:0] opa_tag_i,
	input  logic [PRF_IDX_W-1:0] opb_tag_i,
	input  logic                 opa_rdy_i,
	input  logic                 opb_rdy_i,

	// From decode
	input  logic                 inst_vld_i,
	input  logic [FU_SEL_W-1:0]  fu_sel_i,
	input  logic [IR_W-1:0]      ir_i,
	input  logic [BR_TAG_W-1:0]  br_mask_i,
	input  logic [ROB_IDX_W-1:0] rob_idx_i,

	// Broadcast
	input  logic [PRF_IDX_W-1:0] cdb_tag_i,
	input  logic                 cdb_vld_i,
	input  logic                 stall_dp_i,
	input  logic                 br_recovery_i,
	input  logic [BR_TAG_W-1:0]  br_fix_i,

	// Issue to the functional units
	output logic                 iss_vld_o,
	output logic [PRF_IDX_W-1:0] iss_opa_tag_o,
	output logic [PRF_IDX_W-1:0] iss_opb_tag_o,
	output logic [PRF_IDX_W-1:0] iss_dest_tag_o,
	output logic [FU_SEL_W-1:0]  iss_fu_sel_o,
	output logic [ROB_IDX_W-1:0] iss_rob_idx_o,
	output logic [IR_W-1:0]      iss_ir_o,

	output logic                 full_o
);

	logic                                   dp_en;
	logic [RS_ENT_NUM-1:0]                  avail_vec;
	logic [RS_ENT_NUM-1:0]                  load_vec;
	logic [RS_ENT_NUM-1:0]                  rdy_vec;
	logic [RS_ENT_NUM-1:0]                  allow_vec;
	logic [RS_ENT_NUM-1:0]                  sched_rdy_vec;
	logic [RS_ENT_NUM-1:0]                  iss_vec;
	logic [RS_IDX_W-1:0]                    iss_idx;

	logic [RS_ENT_NUM-1:0][PRF_IDX_W-1:0]   opa_tag_vec;
	logic [RS_ENT_NUM-1:0][PRF_IDX_W-1:0]   opb_tag_vec;
	logic [RS_ENT_NUM-1:0][PRF_IDX_W-1:0]   dest_tag_vec;
	logic [RS_ENT_NUM-1:0][FU_SEL_W-1:0]    fu_sel_vec;
	logic [RS_ENT_NUM-1:0][IR_W-1:0]        ir_vec;
	logic [RS_ENT_NUM-1:0][ROB_IDX_W-1:0]   rob_idx_vec;

	// ********************
	// Entries
	// ********************
	for (genvar i = 0; i < RS_ENT_NUM; i++) begin : g_ent
		rs_entry u_ent (
			.clk           (clk),
			.rst           (rst),
			.dest_tag_i    (dest_tag_i),
			.opa_tag_i     (opa_tag_i),
			.opb_tag_i     (opb_tag_i),
			.opa_rdy_i     (opa_rdy_i),
			.opb_rdy_i     (opb_rdy_i),
			.fu_sel_i      (fu_sel_i),
			.ir_i          (ir_i),
			.rob_idx_i     (rob_idx_i),
			.br_mask_i     (br_mask_i),
			.cdb_tag_i     (cdb_tag_i),
			.cdb_vld_i     (cdb_vld_i),
			.load_i        (load_vec[i]),
			.iss_en_i      (iss_vec[i]),
			.br_recovery_i (br_recovery_i),
			.br_fix_i      (br_fix_i),
			.avail_o       (avail_vec[i]),
			.rdy_o         (rdy_vec[i]),
			.opa_tag_o     (opa_tag_vec[i]),
			.opb_tag_o     (opb_tag_vec[i]),
			.dest_tag_o    (dest_tag_vec[i]),
			.fu_sel_o      (fu_sel_vec[i]),
			.ir_o          (ir_vec[i]),
			.rob_idx_o     (rob_idx_vec[i])
		);
	end

	// ********************
	// Dispatch
	// ********************
	// No dispatch on stall or in a recovery cycle
	assign dp_en = inst_vld_i & ~stall_dp_i & ~br_recovery_i;

	// Lowest free entry takes the instruction
	prio_select #(
		.NUM_BITS (RS_ENT_NUM)
	) u_dp_sel (
		.req_i (avail_vec),
		.en_i  (dp_en),
		.gnt_o (load_vec),
		.idx_o (),
		.any_o ()
	);

	assign full_o = ~(|avail_vec);

	// ********************
	// Issue
	// ********************
	wb_scheduler u_wb_sched (
		.clk          (clk),
		.rst          (rst),
		.fu_sel_vec_i (fu_sel_vec),
		.iss_vld_i    (iss_vld_o),
		.iss_idx_i    (iss_idx),
		.allow_vec_o  (allow_vec)
	);

	// Ready and no writeback collision
	assign sched_rdy_vec = rdy_vec & allow_vec;

	prio_select #(
		.NUM_BITS (RS_ENT_NUM)
	) u_iss_sel (
		.req_i (sched_rdy_vec),
		.en_i  (1'b1),
		.gnt_o (iss_vec),
		.idx_o (iss_idx),
		.any_o (iss_vld_o)
	);

	// Issue mux, fields are only meaningful with iss_vld_o
	assign iss_opa_tag_o = opa_tag_vec[iss_idx];
	assign iss_opb_tag_o = opb_tag_vec[iss_idx];
	assign iss_dest_tag_o = dest_tag_vec[iss_idx];
	assign iss_fu_sel_o = fu_sel_vec[iss_idx];
	assign iss_rob_idx_o = rob_idx_vec[iss_idx];
	assign iss_ir_o = ir_vec[iss_idx];

endmodule

// ==== testbench/rs_tb.sv ====
`timescale 1ns/1ns
// Reservation station testbench: clock, reset, file-driven stimulus,
// output checks against expected issue values, timeout and summary
module rs_tb
	import rs_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 10;
	localparam int DRIVE_DLY = 2;
	localparam int SAMPLE_DLY = CLK_PERIOD - DRIVE_DLY - 1;
	localparam int TAG_NUM = 1 << PRF_IDX_W;

	// Inputs for one cycle and the expected outputs of that cycle
	typedef struct packed {
		logic [15:0]          line_no;
		logic [7:0]           test_num;
		logic                 inst_vld;
		logic [PRF_IDX_W-1:0] dest_tag;
		logic [PRF_IDX_W-1:0] opa_tag;
		logic                 opa_rdy;
		logic [PRF_IDX_W-1:0] opb_tag;
		logic                 opb_rdy;
		logic [FU_SEL_W-1:0]  fu_sel;
		logic [BR_TAG_W-1:0]  br_mask;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [IR_W-1:0]      ir;
		logic                 cdb_vld;
		logic [PRF_IDX_W-1:0] cdb_tag;
		logic                 stall;
		logic                 recovery;
		logic [BR_TAG_W-1:0]  br_fix;
		logic                 exp_vld;
		logic [PRF_IDX_W-1:0] exp_dest;
		logic [FU_SEL_W-1:0]  exp_fu;
		logic                 exp_full;
	} stim_t;

	logic                 clk;
	logic                 rst;
	logic [PRF_IDX_W-1:0] dest_tag;
	logic [PRF_IDX_W-1:0] opa_tag;
	logic [PRF_IDX_W-1:0] opb_tag;
	logic                 opa_rdy;
	logic                 opb_rdy;
	logic                 inst_vld;
	logic [FU_SEL_W-1:0]  fu_sel;
	logic [IR_W-1:0]      ir;
	logic [BR_TAG_W-1:0]  br_mask;
	logic [ROB_IDX_W-1:0] rob_idx;
	logic [PRF_IDX_W-1:0] cdb_tag;
	logic                 cdb_vld;
	logic                 stall_dp;
	logic                 br_recovery;
	logic [BR_TAG_W-1:0]  br_fix;
	logic                 iss_vld;
	logic [PRF_IDX_W-1:0] iss_opa_tag;
	logic [PRF_IDX_W-1:0] iss_opb_tag;
	logic [PRF_IDX_W-1:0] iss_dest_tag;
	logic [FU_SEL_W-1:0]  iss_fu_sel;
	logic [ROB_IDX_W-1:0] iss_rob_idx;
	logic [IR_W-1:0]      iss_ir;
	logic                 full;

	stim_t stim_q[$];
	// Dispatched instruction per destination tag, for the issue payload
	stim_t disp_rec [0:TAG_NUM-1];
	bit disp_seen [0:TAG_NUM-1];
	int err_cnt = 0;
	int check_cnt = 0;
	int test_err = 0;
	int test_cycles = 0;
	int test_pass = 0;
	int test_fail = 0;
	int cycle_cnt = 0;
	int cycle_limit = 0;
	logic [7:0] cur_test = '0;

	rs u_dut (
		.clk            (clk),
		.rst            (rst),
		.dest_tag_i     (dest_tag),
		.opa_tag_i      (opa_tag),
		.opb_tag_i      (opb_tag),
		.opa_rdy_i      (opa_rdy),
		.opb_rdy_i      (opb_rdy),
		.inst_vld_i     (inst_vld),
		.fu_sel_i       (fu_sel),
		.ir_i           (ir),
		.br_mask_i      (br_mask),
		.rob_idx_i      (rob_idx),
		.cdb_tag_i      (cdb_tag),
		.cdb_vld_i      (cdb_vld),
		.stall_dp_i     (stall_dp),
		.br_recovery_i  (br_recovery),
		.br_fix_i       (br_fix),
		.iss_vld_o      (iss_vld),
		.iss_opa_tag_o  (iss_opa_tag),
		.iss_opb_tag_o  (iss_opb_tag),
		.iss_dest_tag_o (iss_dest_tag),
		.iss_fu_sel_o   (iss_fu_sel),
		.iss_rob_idx_o  (iss_rob_idx),
		.iss_ir_o       (iss_ir),
		.full_o         (full)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ********************
	// Stimulus helpers
	// ********************
	task automatic load_stimulus(output bit ok);
		int fd;
		int cnt;
		int line_no;
		int v [20];
		string line;
		stim_t s;
		ok = 1'b0;
		line_no = 0;
		fd = $fopen("testbench/rs_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file testbench/rs_stimulus.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				cnt = $fgets(line, fd);
				line_no++;
				// Skip blank lines and comment lines
				if (cnt > 1 && line.substr(0, 1) != "//") begin
					cnt = $sscanf(line,
						"%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
						v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17],
						v[18], v[19]);
					// Columns in the same order as the struct fields
					s = {16'(line_no), 8'(v[0]), 1'(v[1]), PRF_IDX_W'(v[2]),
						PRF_IDX_W'(v[3]), 1'(v[4]), PRF_IDX_W'(v[5]), 1'(v[6]),
						FU_SEL_W'(v[7]), BR_TAG_W'(v[8]), ROB_IDX_W'(v[9]),
						IR_W'(v[10]), 1'(v[11]), PRF_IDX_W'(v[12]), 1'(v[13]),
						1'(v[14]), BR_TAG_W'(v[15]), 1'(v[16]), PRF_IDX_W'(v[17]),
						FU_SEL_W'(v[18]), 1'(v[19])};
					if (cnt == 20) begin
						stim_q.push_back(s);
					end else begin
						$display("Stimulus line %0d could not be parsed", line_no);
						err_cnt++;
					end
				end
			end
			$fclose(fd);
			ok = (stim_q.size() > 0);
		end
	endtask

	task automatic drive_inputs(input stim_t s);
		inst_vld = s.inst_vld;
		dest_tag = s.dest_tag;
		opa_tag = s.opa_tag;
		opa_rdy = s.opa_rdy;
		opb_tag = s.opb_tag;
		opb_rdy = s.opb_rdy;
		fu_sel = s.fu_sel;
		br_mask = s.br_mask;
		rob_idx = s.rob_idx;
		ir = s.ir;
		cdb_vld = s.cdb_vld;
		cdb_tag = s.cdb_tag;
		stall_dp = s.stall;
		br_recovery = s.recovery;
		br_fix = s.br_fix;
	endtask

	task automatic record_dispatch(input stim_t s);
		if (s.inst_vld) begin
			disp_rec[s.dest_tag] = s;
			disp_seen[s.dest_tag] = 1'b1;
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] exp, input int line_no);
		check_cnt++;
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h (test %0d, stimulus line %0d)",
				name, got, exp, cur_test, line_no);
			err_cnt++;
			test_err++;
		end
	endtask

	// Issue fields only mean something while issue valid is high
	task automatic compare_outputs(input stim_t s);
		stim_t d;
		check_val("iss_vld_o", 32'(iss_vld), 32'(s.exp_vld), int'(s.line_no));
		if (s.exp_vld) begin
			check_val("iss_dest_tag_o", 32'(iss_dest_tag), 32'(s.exp_dest),
				int'(s.line_no));
			check_val("iss_fu_sel_o", 32'(iss_fu_sel), 32'(s.exp_fu), int'(s.line_no));
			if (!disp_seen[s.exp_dest]) begin
				$display("Stimulus line %0d expects tag %h to issue but it was never dispatched",
					s.line_no, s.exp_dest);
				err_cnt++;
				test_err++;
			end else begin
				// Payload comes from the dispatch with the same destination tag
				d = disp_rec[s.exp_dest];
				check_val("iss_opa_tag_o", 32'(iss_opa_tag), 32'(d.opa_tag),
					int'(s.line_no));
				check_val("iss_opb_tag_o", 32'(iss_opb_tag), 32'(d.opb_tag),
					int'(s.line_no));
				check_val("iss_rob_idx_o", 32'(iss_rob_idx), 32'(d.rob_idx),
					int'(s.line_no));
				check_val("iss_ir_o", 32'(iss_ir), 32'(d.ir), int'(s.line_no));
			end
		end
		check_val("full_o", 32'(full), 32'(s.exp_full), int'(s.line_no));
	endtask

	task automatic report_test();
		if (test_err == 0) begin
			$display("test %0d passed in %0d cycles", cur_test, test_cycles);
			test_pass++;
		end else begin
			$display("test %0d failed with %0d mismatches", cur_test, test_err);
			test_fail++;
		end
		test_err = 0;
		test_cycles = 0;
	endtask

	// ********************
	// Watchdog
	// ********************
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("Timeout after %0d cycles, the stimulus did not run to its end",
				cycle_cnt);
			$display("Simulation failed");
			$finish;
		end
	end

	// ********************
	// Main sequence
	// ********************
	initial begin
		bit ok;
		stim_t s;
		rst = 1'b1;
		drive_inputs('0);
		load_stimulus(ok);
		if (!ok) begin
			$display("No usable stimulus lines, nothing was run");
			$display("Simulation failed");
			$finish;
		end else begin
			cycle_limit = 2 * stim_q.size() + 50;
			repeat (RST_CYCLES) @(posedge clk);
			#DRIVE_DLY;
			rst = 1'b0;
			for (int k = 0; k < stim_q.size(); k++) begin
				s = stim_q[k];
				if (k > 0 && s.test_num != cur_test)
					report_test();
				cur_test = s.test_num;
				drive_inputs(s);
				// Sample just before the next rising edge
				#SAMPLE_DLY;
				compare_outputs(s);
				record_dispatch(s);
				test_cycles++;
				@(posedge clk);
				#DRIVE_DLY;
			end
			report_test();
			$display("tests %0d, passed %0d, failed %0d, checks %0d, mismatches %0d",
				test_pass + test_fail, test_pass, test_fail, check_cnt, err_cnt);
			if (err_cnt == 0 && test_fail == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

// ==== testbench/rs_stimulus.txt ====
// test inst_vld dest opa_tag opa_rdy opb_tag opb_rdy fu br_mask rob ir cdb_vld cdb_tag
// stall recovery br_fix, then expected: iss_vld dest fu full (all hex but test)
// 1: ready dispatches issue the next cycle in order
1 1 10 01 1 02 1 0 0 01 00000101 0 00 0 0 0 0 00 0 0
1 1 11 01 1 02 1 2 0 02 00000102 0 00 0 0 0 1 10 0 0
1 1 12 03 1 02 1 4 0 03 00000103 0 00 0 0 0 1 11 2 0
1 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 12 4 0
1 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 0 00 0 0
// 2: operand B wakeup from the CDB, also in the dispatch cycle
2 1 14 04 1 15 0 0 0 04 00000201 0 00 0 0 0 0 00 0 0
2 0 00 00 0 00 0 0 0 00 00000000 1 16 0 0 0 0 00 0 0
2 0 00 00 0 00 0 0 0 00 00000000 1 15 0 0 0 0 00 0 0
2 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 14 0 0
2 1 17 05 1 18 0 1 0 05 00000202 1 18 0 0 0 0 00 0 0
2 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 17 1 0
2 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 0 00 0 0
// 3: lowest index wins when several entries wake together
3 1 19 1C 0 06 1 0 0 06 00000301 0 00 0 0 0 0 00 0 0
3 1 1A 1D 0 06 1 0 0 07 00000302 0 00 0 0 0 0 00 0 0
3 1 1B 1D 0 06 1 0 0 08 00000303 0 00 0 0 0 0 00 0 0
3 0 00 00 0 00 0 0 0 00 00000000 1 1C 0 0 0 0 00 0 0
3 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 19 0 0
3 1 1E 1D 0 06 1 1 0 09 00000304 0 00 0 0 0 0 00 0 0
3 0 00 00 0 00 0 0 0 00 00000000 1 1D 0 0 0 0 00 0 0
3 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 1E 1 0
3 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 1A 0 0
3 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 1B 0 0
3 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 0 00 0 0
// 4: ALU held one cycle behind a MULT, LOAD goes first
4 1 20 07 1 21 0 0 0 0A 00000401 0 00 0 0 0 0 00 0 0
4 1 22 08 1 09 1 5 0 0B 00000402 0 00 0 0 0 0 00 0 0
4 1 23 0A 1 21 0 3 0 0C 00000403 0 00 0 0 0 1 22 5 0
4 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 0 00 0 0
4 0 00 00 0 00 0 0 0 00 00000000 1 21 0 0 0 0 00 0 0
4 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 23 3 0
4 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 20 0 0
4 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 0 00 0 0
4 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 0 00 0 0
// 5: eight waiting entries raise full, one issue clears it
5 1 31 30 0 0B 1 0 1 10 00000501 0 00 0 0 0 0 00 0 0
5 1 32 30 0 0B 1 0 2 11 00000502 0 00 0 0 0 0 00 0 0
5 1 33 30 0 0B 1 0 1 12 00000503 0 00 0 0 0 0 00 0 0
5 1 34 30 0 0B 1 0 4 13 00000504 0 00 0 0 0 0 00 0 0
5 1 35 30 0 0B 1 0 2 14 00000505 0 00 0 0 0 0 00 0 0
5 1 36 2F 0 0B 1 0 0 15 00000506 0 00 0 0 0 0 00 0 0
5 1 37 30 0 0B 1 0 8 16 00000507 0 00 0 0 0 0 00 0 0
5 1 38 30 0 0B 1 0 1 17 00000508 0 00 0 0 0 0 00 0 0
5 1 3E 0C 1 0D 1 0 0 18 00000509 0 00 1 0 0 0 00 0 1
5 1 3F 0C 1 0D 1 0 0 19 0000050A 1 2F 0 0 0 0 00 0 1
5 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 36 0 1
5 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 0 00 0 0
// 6: recovery squashes mask 1 entries and blocks the dispatch
6 1 39 30 0 0B 1 0 1 1A 00000601 0 00 0 0 0 0 00 0 0
6 1 3A 0E 1 0F 1 0 0 1B 00000602 0 00 0 1 1 0 00 0 1
6 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 0 00 0 0
6 0 00 00 0 00 0 0 0 00 00000000 1 30 0 0 0 0 00 0 0
6 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 32 0 0
6 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 34 0 0
6 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 35 0 0
6 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 1 37 0 0
6 0 00 00 0 00 0 0 0 00 00000000 0 00 0 0 0 0 00 0 0

// ==== sources.f ====
rtl/rs_pkg.sv
rtl/rs_entry.sv
rtl/prio_select.sv
rtl/wb_scheduler.sv
rtl/rs.sv
testbench/rs_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the reservation station testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns --top-module rs_tb \
	-f sources.f -o rs_tb_sim \
	&& ./obj_dir/rs_tb_sim | tee /dev/stderr | grep "Simulation passed" > /dev/null \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail"; exit 1; }
